// ==== pit_macros.svh ====
`ifndef PIT_MACROS_SVH
`define PIT_MACROS_SVH

// three counters, as on the 8253
`define PIT_NUM_COUNTERS 3

// host bus is one byte wide
`define PIT_DATA_W 8

// full count element, two bytes
`define PIT_COUNT_W 16

`endif

// ==== pit_pkg.sv ====
package pit_pkg;

	typedef enum logic [1:0] {
		rl_latch = 2'b00, // counter latch command
		rl_lsb   = 2'b01,
		rl_msb   = 2'b10,
		rl_both  = 2'b11  // lsb first, then msb
	} rl_e;

	typedef enum logic [2:0] {
		m0 = 3'd0, // interrupt on terminal count
		m1 = 3'd1, // unsupported one-shot
		m2 = 3'd2, // rate generator
		m3 = 3'd3, // square wave
		m4 = 3'd4, // software strobe
		m5 = 3'd5  // unsupported hardware strobe
	} mode_e;

	typedef struct packed {
		logic [1:0] sel;
		rl_e        rl;
		logic [2:0] mode; // raw code, 6 and 7 still unfolded
		logic       bcd;
	} mode_word_s;

	typedef struct packed {
		logic [1:0] sel;
		logic [1:0] zero; // 00 marks a latch command
		logic [3:0] unused;
	} latch_word_s;

	// one control byte seen both ways
	typedef union packed {
		mode_word_s  mw;
		latch_word_s lw;
	} cw_u;

endpackage

// ==== pit_ctrl_if.sv ====
`timescale 1ns/1ns
`include "pit_macros.svh"

interface pit_ctrl_if;

	logic [5:0]             cw;     // control byte without select
	logic                   cw_set; // mode-set pulse
	logic                   latch;  // latch command pulse
	logic [`PIT_DATA_W-1:0] data;   // host write byte
	logic                   wr_en;
	logic                   rd_en;
	logic [`PIT_DATA_W-1:0] q;      // byte from the last read

	modport dec (
		output cw,
		output cw_set,
		output latch,
		output data,
		output wr_en,
		output rd_en,
		input  q
	);

	modport cnt (
		input  cw,
		input  cw_set,
		input  latch,
		input  data,
		input  wr_en,
		input  rd_en,
		output q
	);

endinterface

// ==== pit_down_counter.sv ====
`timescale 1ns/1ns
`include "pit_macros.svh"

module pit_down_counter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    en,
	input  logic                    load,
	input  logic                    bcd,
	input  logic                    half_step, // square wave counts by two
	input  logic                    out_state,
	input  logic [`PIT_COUNT_W-1:0] d,
	output logic [`PIT_COUNT_W-1:0] q
);

	logic [1:0]              step;
	logic [`PIT_COUNT_W-1:0] next_bin;
	logic [`PIT_COUNT_W-1:0] next_bcd;

	// digit-wise subtract with borrow, wraps 0000 to 9999
	function automatic logic [`PIT_COUNT_W-1:0] bcd_sub(input logic [`PIT_COUNT_W-1:0] v,
		input logic [1:0] s);
		logic [`PIT_COUNT_W-1:0] r;
		logic [4:0]              dig;
		logic [1:0]              sub;
		sub = s;
		for (int i = 0; i < `PIT_COUNT_W / 4; i++) begin
			dig = {1'b0, v[i*4 +: 4]} - {3'b000, sub};
			if (dig[4]) begin
				dig = dig + 5'd10;
				sub = 2'd1;
			end else begin
				sub = 2'd0;
			end
			r[i*4 +: 4] = dig[3:0];
		end
		return r;
	endfunction

	function automatic logic bcd_valid(input logic [`PIT_COUNT_W-1:0] v);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `PIT_COUNT_W / 4; i++) begin
			if (v[i*4 +: 4] > 4'd9) ok = 1'b0;
		end
		return ok;
	endfunction

	// odd counts take one extra or one fewer depending on the out half
	always_comb begin
		if (!half_step) step = 2'd1;
		else if (!q[0]) step = 2'd2;
		else if (out_state) step = 2'd1;
		else step = 2'd3;
	end

	assign next_bin = q - {{(`PIT_COUNT_W-2){1'b0}}, step};
	assign next_bcd = bcd_sub(q, step);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (load) begin
			q <= d;
		end else if (en) begin
			q <= bcd ? next_bcd : next_bin;
		end
	end

	a_bcd_digits: assert property (@(posedge clk) disable iff (!rst_n)
		bcd && (load ? bcd_valid(d) : (en && bcd_valid(q))) |=> bcd_valid(q))
		else $error("bcd digit above nine");

endmodule

// ==== pit_bus_decode.sv ====
`timescale 1ns/1ns
`include "pit_macros.svh"

module pit_bus_decode (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ce,
	input  logic [1:0]             a,
	input  logic                   wr,
	input  logic                   rd,
	input  logic [`PIT_DATA_W-1:0] din,
	output logic [`PIT_DATA_W-1:0] dout,
	pit_ctrl_if.dec                ctl0,
	pit_ctrl_if.dec                ctl1,
	pit_ctrl_if.dec                ctl2
);

	pit_pkg::cw_u cw_in;
	logic         wr_acc;
	logic         rd_acc;
	logic         is_latch;
	logic [2:0]   sel_oh; // counter hit by a control write
	logic [1:0]   rd_sel; // counter read last

	assign cw_in    = din;
	assign wr_acc   = ce & wr;
	assign rd_acc   = ce & rd;
	assign is_latch = (cw_in.lw.zero == 2'b00);

	always_comb begin
		sel_oh = 3'b000;
		if (wr_acc && a == 2'd3 && cw_in.mw.sel != 2'd3) begin // select 3 ignored
			sel_oh[cw_in.mw.sel] = 1'b1;
		end
	end

	assign ctl0.cw     = din[5:0];
	assign ctl0.data   = din;
	assign ctl0.cw_set = sel_oh[0] & ~is_latch;
	assign ctl0.latch  = sel_oh[0] & is_latch;
	assign ctl0.wr_en  = wr_acc & (a == 2'd0);
	assign ctl0.rd_en  = rd_acc & (a == 2'd0);

	assign ctl1.cw     = din[5:0];
	assign ctl1.data   = din;
	assign ctl1.cw_set = sel_oh[1] & ~is_latch;
	assign ctl1.latch  = sel_oh[1] & is_latch;
	assign ctl1.wr_en  = wr_acc & (a == 2'd1);
	assign ctl1.rd_en  = rd_acc & (a == 2'd1);

	assign ctl2.cw     = din[5:0];
	assign ctl2.data   = din;
	assign ctl2.cw_set = sel_oh[2] & ~is_latch;
	assign ctl2.latch  = sel_oh[2] & is_latch;
	assign ctl2.wr_en  = wr_acc & (a == 2'd2);
	assign ctl2.rd_en  = rd_acc & (a == 2'd2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_sel <= 2'd3; // nothing read yet
		end else if (rd_acc) begin
			rd_sel <= a;
		end
	end

	// each unit holds its read byte, so dout stays put between reads
	always_comb begin
		case (rd_sel)
			2'd0:    dout = ctl0.q;
			2'd1:    dout = ctl1.q;
			2'd2:    dout = ctl2.q;
			default: dout = '0;
		endcase
	end

	a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({ctl0.cw_set | ctl0.latch, ctl1.cw_set | ctl1.latch, ctl2.cw_set | ctl2.latch}))
		else $error("control word reached more than one counter");

endmodule

// ==== pit_counter_unit.sv ====
`timescale 1ns/1ns
`include "pit_macros.svh"

module pit_counter_unit (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    tce,
	input  logic    gate,
	output logic    out,
	pit_ctrl_if.cnt ctl
);

	pit_pkg::cw_u             cw_in;
	pit_pkg::mode_e           new_mode;
	pit_pkg::mode_e           mode;
	pit_pkg::rl_e             rl;
	logic                     bcd;
	logic [`PIT_COUNT_W-1:0]  count_reg; // initial count, used for reloads
	logic [`PIT_DATA_W-1:0]   lsb_stage;
	logic                     load_msb;  // two-byte load half done
	logic                     pending;   // count written, waiting for tce
	logic                     running;
	logic                     out_reg;
	logic [`PIT_COUNT_W-1:0]  latch_val;
	logic                     latched;
	logic                     rd_msb;
	logic [`PIT_DATA_W-1:0]   q_reg;
	logic [`PIT_COUNT_W-1:0]  cnt_q;
	logic [`PIT_COUNT_W-1:0]  cur_val;
	logic [`PIT_COUNT_W-1:0]  rd_src;
	logic                     mode_ok;
	logic                     step_ok;
	logic                     take;
	logic                     reload;
	logic                     tc;

	assign cw_in = {2'b00, ctl.cw};
	// codes 6 and 7 fold onto modes 2 and 3
	assign new_mode = pit_pkg::mode_e'((cw_in.mw.mode[2:1] == 2'b11) ?
		{1'b0, cw_in.mw.mode[1:0]} : cw_in.mw.mode);

	assign mode_ok = (mode != pit_pkg::m1) && (mode != pit_pkg::m5);
	assign step_ok = tce & gate & running & ~pending & ~load_msb;
	assign take    = tce & pending & ~load_msb; // new count enters, no decrement
	assign reload  = step_ok & (((mode == pit_pkg::m2) && (cnt_q == 16'd1)) ||
		((mode == pit_pkg::m3) && (cnt_q == 16'd2)));
	assign tc      = step_ok & ((mode == pit_pkg::m0) || (mode == pit_pkg::m4)) &
		(cnt_q == 16'd1);

	// count not yet in the counter still reads back as written
	assign cur_val = pending ? count_reg : cnt_q;
	assign rd_src  = latched ? latch_val : cur_val;

	pit_down_counter i_dc (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (step_ok & ~reload),
		.load      (take | reload),
		.bcd       (bcd),
		.half_step (mode == pit_pkg::m3),
		.out_state (out_reg),
		.d         (count_reg),
		.q         (cnt_q)
	);

	always_ff @(posedge clk) begin
		if (ctl.wr_en) begin
			case (rl)
				pit_pkg::rl_lsb: count_reg <= {{`PIT_DATA_W{1'b0}}, ctl.data};
				pit_pkg::rl_msb: count_reg <= {ctl.data, {`PIT_DATA_W{1'b0}}};
				pit_pkg::rl_both: begin
					if (load_msb) begin
						count_reg <= {ctl.data, lsb_stage};
					end else begin
						lsb_stage <= ctl.data;
					end
				end
				default: ; // unprogrammed
			endcase
		end
		if (ctl.latch && !latched) begin
			latch_val <= cur_val; // a second latch is ignored until read
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode     <= pit_pkg::m0;
			rl       <= pit_pkg::rl_latch;
			bcd      <= 1'b0;
			load_msb <= 1'b0;
			pending  <= 1'b0;
			running  <= 1'b0;
			out_reg  <= 1'b1;
			latched  <= 1'b0;
			rd_msb   <= 1'b0;
			q_reg    <= '0;
		end else begin
			if (take) begin
				pending <= 1'b0;
				running <= mode_ok;
			end

			case (mode)
				pit_pkg::m0: if (tc) out_reg <= 1'b1;
				pit_pkg::m2: begin
					if (reload) out_reg <= 1'b0;
					else if (tce) out_reg <= 1'b1;
				end
				pit_pkg::m3: if (reload) out_reg <= ~out_reg;
				pit_pkg::m4: begin
					if (tc) out_reg <= 1'b0;
					else if (tce) out_reg <= 1'b1; // strobe lasts one tce
				end
				default: out_reg <= 1'b1;
			endcase
			if (tc) begin
				running <= 1'b0; // one-shot modes stop at zero
			end

			if (ctl.wr_en) begin
				case (rl)
					pit_pkg::rl_lsb, pit_pkg::rl_msb: pending <= 1'b1;
					pit_pkg::rl_both: begin
						load_msb <= ~load_msb;
						if (load_msb) pending <= 1'b1;
					end
					default: ;
				endcase
				if (mode == pit_pkg::m0 && rl != pit_pkg::rl_latch) begin
					out_reg <= 1'b0; // new count rearms mode 0
				end
			end

			if (ctl.latch) begin
				latched <= 1'b1;
			end

			if (ctl.rd_en) begin
				case (rl)
					pit_pkg::rl_lsb: begin
						q_reg   <= rd_src[7:0];
						latched <= 1'b0;
					end
					pit_pkg::rl_msb: begin
						q_reg   <= rd_src[15:8];
						latched <= 1'b0;
					end
					pit_pkg::rl_both: begin
						rd_msb <= ~rd_msb;
						if (rd_msb) begin
							q_reg   <= rd_src[15:8];
							latched <= 1'b0; // released after the msb
						end else begin
							q_reg <= rd_src[7:0];
						end
					end
					default: q_reg <= '0;
				endcase
			end

			// mode set wins over everything above
			if (ctl.cw_set) begin
				mode     <= new_mode;
				rl       <= cw_in.mw.rl;
				bcd      <= cw_in.mw.bcd;
				load_msb <= 1'b0;
				pending  <= 1'b0;
				running  <= 1'b0;
				latched  <= 1'b0;
				rd_msb   <= 1'b0;
				out_reg  <= (new_mode != pit_pkg::m0);
			end
		end
	end

	assign ctl.q = q_reg;
	assign out   = out_reg;

	a_no_reload_half: assert property (@(posedge clk) disable iff (!rst_n)
		load_msb |=> $stable(cnt_q))
		else $error("count changed during a two-byte load");

endmodule

// ==== pit8253.sv ====
`timescale 1ns/1ns
`include "pit_macros.svh"

module pit8253 (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         ce,   // bus clock enable
	input  logic                         tce,  // timer clock enable
	input  logic [1:0]                   a,
	input  logic                         wr,
	input  logic                         rd,
	input  logic [`PIT_DATA_W-1:0]       din,
	output logic [`PIT_DATA_W-1:0]       dout,
	input  logic [`PIT_NUM_COUNTERS-1:0] gate,
	output logic [`PIT_NUM_COUNTERS-1:0] out
);

	pit_ctrl_if ctl0 ();
	pit_ctrl_if ctl1 ();
	pit_ctrl_if ctl2 ();

	pit_bus_decode i_dec (
		.clk   (clk),
		.rst_n (rst_n),
		.ce    (ce),
		.a     (a),
		.wr    (wr),
		.rd    (rd),
		.din   (din),
		.dout  (dout),
		.ctl0  (ctl0.dec),
		.ctl1  (ctl1.dec),
		.ctl2  (ctl2.dec)
	);

	pit_counter_unit i_cnt0 (
		.clk   (clk),
		.rst_n (rst_n),
		.tce   (tce),
		.gate  (gate[0]),
		.out   (out[0]),
		.ctl   (ctl0.cnt)
	);

	pit_counter_unit i_cnt1 (
		.clk   (clk),
		.rst_n (rst_n),
		.tce   (tce),
		.gate  (gate[1]),
		.out   (out[1]),
		.ctl   (ctl1.cnt)
	);

	pit_counter_unit i_cnt2 (
		.clk   (clk),
		.rst_n (rst_n),
		.tce   (tce),
		.gate  (gate[2]),
		.out   (out[2]),
		.ctl   (ctl2.cnt)
	);

endmodule

// ==== pit_tb_table.svh ====
`ifndef PIT_TB_TABLE_SVH
`define PIT_TB_TABLE_SVH

// columns: name, counter, control byte, count, tce pulses, expected value
// control byte is sel[7:6] rl[5:4] mode[3:1] bcd[0]
// pulses 0 is a plain readback with tce held low
// expected is the count read back in mode 0, the out period in mode 2,
// the half period in mode 3 and the pulse carrying the strobe in mode 4

localparam int NUM_ROWS = 11;

string       row_name   [NUM_ROWS];
logic [1:0]  row_cnt    [NUM_ROWS];
logic [7:0]  row_cw     [NUM_ROWS];
logic [15:0] row_count  [NUM_ROWS];
int          row_pulses [NUM_ROWS];
logic [15:0] row_expect [NUM_ROWS];

task automatic set_row(input int i, input string name, input logic [1:0] c,
	input logic [7:0] cw, input logic [15:0] cnt, input int pulses,
	input logic [15:0] expected);
	row_name[i]   = name;
	row_cnt[i]    = c;
	row_cw[i]     = cw;
	row_count[i]  = cnt;
	row_pulses[i] = pulses;
	row_expect[i] = expected;
endtask

task automatic fill_table();
	set_row(0,  "rb_c0_both",   2'd0, 8'h30, 16'h1234, 0,  16'h1234);
	set_row(1,  "rb_c1_lsb",    2'd1, 8'h50, 16'h00a7, 0,  16'h00a7);
	set_row(2,  "rb_c2_msb",    2'd2, 8'ha0, 16'h5c00, 0,  16'h005c); // only the msb byte
	set_row(3,  "rb_c2_both",   2'd2, 8'hb0, 16'hbeef, 0,  16'hbeef);
	set_row(4,  "m0_gate_c1",   2'd1, 8'h70, 16'd7,    7,  16'h0000);
	set_row(5,  "m0_bcd_c0",    2'd0, 8'h31, 16'h0010, 5,  16'h0005); // 10 down to 05
	set_row(6,  "m2_rate_c2",   2'd2, 8'hb4, 16'd5,    12, 16'd5);
	set_row(7,  "m3_square_c0", 2'd0, 8'h36, 16'd6,    14, 16'd3);
	set_row(8,  "m4_strobe_c1", 2'd1, 8'h78, 16'd4,    8,  16'd4);
	set_row(9,  "m2_lsb_c0",    2'd0, 8'h14, 16'd3,    8,  16'd3);
	set_row(10, "m3_code7_c2",  2'd2, 8'hbe, 16'd8,    18, 16'd4); // code 7 acts as mode 3
endtask

`endif

// ==== tb_pit8253.sv ====
`timescale 1ns/1ns
`include "pit_macros.svh"

module tb_pit8253;

	localparam int CLK_PERIOD = 4;

	logic                         clk;
	logic                         rst_n;
	logic                         ce;
	logic                         tce;
	logic [1:0]                   a;
	logic                         wr;
	logic                         rd;
	logic [`PIT_DATA_W-1:0]       din;
	logic [`PIT_DATA_W-1:0]       dout;
	logic [`PIT_NUM_COUNTERS-1:0] gate;
	logic [`PIT_NUM_COUNTERS-1:0] out;

	int n_checks;
	int n_errors;
	int row_errors;
	int n_rows_failed;
	bit table_ready;

	`include "pit_tb_table.svh"

	pit8253 i_dut (
		.clk   (clk),
		.rst_n (rst_n),
		.ce    (ce),
		.tce   (tce),
		.a     (a),
		.wr    (wr),
		.rd    (rd),
		.din   (din),
		.dout  (dout),
		.gate  (gate),
		.out   (out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			row_errors++;
			$display("MISMATCH %s: expected %h, actual %h", what, expected, actual);
		end
	endtask

	task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
		@(posedge clk);
		a   <= addr;
		din <= data;
		wr  <= 1'b1;
		@(posedge clk);
		wr  <= 1'b0; // held for one edge only
	endtask

	task automatic bus_read(input logic [1:0] addr, output logic [7:0] data);
		@(posedge clk);
		a  <= addr;
		rd <= 1'b1;
		@(posedge clk);
		rd <= 1'b0;
		@(negedge clk);
		data = dout;
	endtask

	// one tce edge, out sampled half a cycle later
	task automatic tce_pulse(input logic [1:0] c, output logic o);
		@(posedge clk);
		tce <= 1'b1;
		@(posedge clk);
		tce <= 1'b0;
		@(negedge clk);
		o = out[c];
	endtask

	task automatic set_gate(input logic [1:0] c, input logic v);
		@(posedge clk);
		gate[c] <= v;
	endtask

	task automatic load_count(input logic [1:0] c, input logic [7:0] cw,
		input logic [15:0] cnt);
		bus_write(2'd3, cw);
		if (cw[4]) bus_write(c, cnt[7:0]);  // lsb byte
		if (cw[5]) bus_write(c, cnt[15:8]); // msb byte
	endtask

	task automatic read_count(input logic [1:0] c, input logic [1:0] fmt,
		output logic [15:0] val);
		logic [7:0] lo;
		logic [7:0] hi;
		bus_write(2'd3, {c, 6'b000000}); // counter latch command
		bus_read(c, lo);
		if (fmt == 2'b11) begin
			bus_read(c, hi);
			val = {hi, lo};
		end else begin
			val = {8'h00, lo};
		end
	endtask

	task automatic run_row(input int i);
		logic [1:0]  c;
		logic [2:0]  mode;
		logic [1:0]  fmt;
		logic [15:0] val;
		logic        o;
		logic        prev;
		int          falls[4];
		int          rises[4];
		int          nf;
		int          nr;
		c    = row_cnt[i];
		fmt  = row_cw[i][5:4];
		mode = row_cw[i][3:1];
		if (mode[2:1] == 2'b11) mode[2] = 1'b0; // codes 6 and 7
		nf = 0;
		nr = 0;
		for (int k = 0; k < 4; k++) begin
			falls[k] = -1;
			rises[k] = -1;
		end
		load_count(c, row_cw[i], row_count[i]);
		if (row_pulses[i] == 0) begin
			read_count(c, fmt, val);
			check_value({row_name[i], " readback"}, row_expect[i], val);
		end else if (mode == 3'd0) begin
			@(negedge clk);
			check_value({row_name[i], " out after load"}, 16'd0, {15'd0, out[c]});
			set_gate(c, 1'b0);
			repeat (3) tce_pulse(c, o); // first edge only takes the count
			read_count(c, fmt, val);
			check_value({row_name[i], " count with gate low"}, row_count[i], val);
			set_gate(c, 1'b1);
			repeat (row_pulses[i]) tce_pulse(c, o);
			read_count(c, fmt, val);
			check_value({row_name[i], " count"}, row_expect[i], val);
			check_value({row_name[i], " out"}, 16'(row_expect[i] == 16'd0),
				{15'd0, out[c]});
		end else begin
			tce_pulse(c, prev);
			for (int k = 1; k <= row_pulses[i]; k++) begin
				tce_pulse(c, o);
				if (prev && !o && nf < 4) begin
					falls[nf] = k;
					nf++;
				end
				if (!prev && o && nr < 4) begin
					rises[nr] = k;
					nr++;
				end
				prev = o;
			end
			case (mode)
				3'd2: begin
					check_value({row_name[i], " period"}, row_expect[i],
						16'(falls[1] - falls[0]));
					check_value({row_name[i], " low width"}, 16'd1, 16'(rises[0] - falls[0]));
				end
				3'd3: begin
					check_value({row_name[i], " low half"}, row_expect[i],
						16'(rises[0] - falls[0]));
					check_value({row_name[i], " high half"}, row_expect[i],
						16'(falls[1] - rises[0]));
				end
				default: begin
					check_value({row_name[i], " strobe edge"}, row_expect[i], 16'(falls[0]));
					check_value({row_name[i], " low width"}, 16'd1, 16'(rises[0] - falls[0]));
					check_value({row_name[i], " strobes"}, 16'd1, 16'(nf));
				end
			endcase
		end
	endtask

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		ce    = 1'b1;
		tce   = 1'b0;
		a     = 2'd0;
		wr    = 1'b0;
		rd    = 1'b0;
		din   = '0;
		gate  = '1;
		n_checks      = 0;
		n_errors      = 0;
		n_rows_failed = 0;
		fill_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			row_errors = 0;
			run_row(i);
			if (row_errors == 0) begin
				$display("test %s: ok", row_name[i]);
			end else begin
				n_rows_failed++;
				$display("test %s: %0d mismatches", row_name[i], row_errors);
			end
		end
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			NUM_ROWS, n_rows_failed, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// about two cycles per tce pulse plus bus traffic per row
	initial begin
		int budget;
		wait (table_ready);
		budget = 40;
		for (int i = 0; i < NUM_ROWS; i++) begin
			budget += 4 * (row_pulses[i] + 3) + 80;
		end
		#(budget * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d clock cycles", budget);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== pit8253.f ====
+incdir+.
pit_pkg.sv
pit_ctrl_if.sv
pit_down_counter.sv
pit_bus_decode.sv
pit_counter_unit.sv
pit8253.sv
tb_pit8253.sv
